// ==== cache_system.f ====
logic/cache_pkg.sv
logic/cache_datapath.sv
logic/cache_control.sv
logic/cache.sv
logic/memory_arbiter.sv
logic/main_memory.sv
logic/cache_system.sv
dv/cache_system_tb.sv

// ==== dv/cache_system_tb.sv ====
`timescale 1ns/100ps

module cache_system_tb import cache_pkg::*; ();

    localparam int ack_timeout = 200;                 // Cycles allowed per access
    localparam int region_words = 512;                // Words in one port's half of memory

    logic     clk = 1'b0;
    logic     reset;
    cpu_req_t cpu_req [num_ports];
    cpu_rsp_t cpu_rsp [num_ports];

    logic [7:0]  model_mem [2**addr_width];           // Byte model of memory
    logic [31:0] lcg_state [num_ports];               // One generator per port
    int          reads_checked = 0;
    int          cycles;

    cache_system i_dut (
        .clk,
        .reset,
        .cpu_req,
        .cpu_rsp
    );

    always #20 clk = ~clk;                            // 40 ns period

    function automatic logic [31:0] next_rand(input int p);
        lcg_state[p] = lcg_state[p] * 32'd1664525 + 32'd1013904223;
        return lcg_state[p];
    endfunction

    // Applies a write under its byte mask and returns the word now held
    function automatic logic [31:0] model_access(input logic we, input logic [11:0] adr,
                                                 input logic [3:0] sel, input logic [31:0] dat);
        logic [11:0] base;
        logic [31:0] word;
        base = {adr[11:2], 2'b00};                    // Word aligned
        for (int b = 0; b < word_bytes; b++) begin
            if (we && sel[b]) model_mem[base + b] = dat[b*8 +: 8];
            word[b*8 +: 8] = model_mem[base + b];
        end
        return word;
    endfunction

    task automatic fail_stop(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            fail_stop($sformatf("ERR %s: got 0x%h, expected 0x%h", name, actual, expected));
        end
    endtask

    // One processor access, returns cycles from stb to ack
    task automatic bus_access(input int p, input logic we, input logic [11:0] adr,
                              input logic [3:0] sel, input logic [31:0] dat, output int n);
        @(negedge clk);
        cpu_req[p] = '{stb: 1'b1, we: we, adr: adr, sel: sel, dat: dat};
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!cpu_rsp[p].ack && n < ack_timeout);
        if (!cpu_rsp[p].ack) begin
            fail_stop($sformatf("Port %0d got no ack within %0d cycles", p, ack_timeout));
        end
        @(negedge clk);                               // Hold through the ack edge
        cpu_req[p].stb = 1'b0;
    endtask

    task automatic init_region(input int p);
        int n;
        for (int w = 0; w < region_words; w++) begin
            bus_access(p, 1'b1, {1'(p), 9'(w), 2'b00}, 4'hf, next_rand(p), n);
        end
    endtask

    task automatic run_random(input int p, input int count);
        logic [31:0] r;
        logic [3:0]  sel;
        int          n;
        for (int i = 0; i < count; i++) begin
            r   = next_rand(p);
            sel = (r[21:18] == 4'h0) ? 4'hf : r[21:18]; // Never an empty mask
            bus_access(p, r[31], {1'(p), r[30:22], 2'b00}, sel, next_rand(p), n);
        end
    endtask

    // Every ack updates the model; reads are compared against it
    always @(negedge clk) begin : compare_reads
        logic [31:0] expected;
        if (!reset) begin
            for (int p = 0; p < num_ports; p++) begin
                if (cpu_rsp[p].ack) begin
                    expected = model_access(cpu_req[p].we, cpu_req[p].adr,
                                            cpu_req[p].sel, cpu_req[p].dat);
                    if (!cpu_req[p].we) begin
                        reads_checked++;
                        check_value($sformatf("cpu_rsp[%0d].dat", p), cpu_rsp[p].dat, expected);
                    end
                end
            end
        end
    end

    initial begin
        reset = 1'b1;
        for (int p = 0; p < num_ports; p++) begin
            cpu_req[p]   = '0;
            lcg_state[p] = 32'h1d19e263;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_value("cpu_rsp[0].ack", 32'(cpu_rsp[0].ack), 32'h0); // Quiet after reset
        check_value("cpu_rsp[1].ack", 32'(cpu_rsp[1].ack), 32'h0);

        fork                                          // Whole region written before reads
            init_region(0);
            init_region(1);
        join

        // Write then read back, read must hit
        bus_access(0, 1'b1, 12'h010, 4'hf, 32'hcafe_0010, cycles);
        bus_access(0, 1'b0, 12'h010, 4'hf, 32'h0, cycles);
        check_value("cpu_rsp[0].ack latency", 32'(cycles), 32'd2);
        bus_access(1, 1'b1, 12'h814, 4'hf, 32'hbeef_0814, cycles);
        bus_access(1, 1'b0, 12'h814, 4'hf, 32'h0, cycles);
        check_value("cpu_rsp[1].ack latency", 32'(cycles), 32'd2);

        // Partial writes merged into one word
        bus_access(0, 1'b1, 12'h128, 4'b0001, 32'h1111_1111, cycles);
        bus_access(0, 1'b1, 12'h128, 4'b0110, 32'h2222_2222, cycles);
        bus_access(0, 1'b1, 12'h128, 4'b1000, 32'h3333_3333, cycles);
        bus_access(0, 1'b1, 12'h128, 4'b1010, 32'h4444_4444, cycles);
        bus_access(0, 1'b0, 12'h128, 4'hf, 32'h0, cycles);

        // Six tags on set 5 force dirty evictions
        for (int t = 0; t < 6; t++) begin
            bus_access(0, 1'b1, {5'(t), 3'd5, 4'h4}, 4'hf, next_rand(0), cycles);
        end
        for (int t = 0; t < 6; t++) begin
            bus_access(0, 1'b0, {5'(t), 3'd5, 4'h4}, 4'hf, 32'h0, cycles);
        end

        fork                                          // Both ports contend for the bus
            run_random(0, 400);
            run_random(1, 400);
        join

        $display("Reads checked: %0d", reads_checked);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule : cache_system_tb

// ==== logic/cache_system.sv ====
`timescale 1ns/100ps

module cache_system import cache_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  cpu_req_t cpu_req [num_ports],             // Processor ports
    output cpu_rsp_t cpu_rsp [num_ports]
);

    mem_req_t cache_mem_req [num_ports];              // Cache side of the bus
    mem_rsp_t cache_mem_rsp [num_ports];
    mem_req_t mem_req;                                // Memory side of the bus
    mem_rsp_t mem_rsp;

    for (genvar p = 0; p < num_ports; p++) begin : g_port
        cache i_cache (
            .clk,
            .reset,
            .cpu_req (cpu_req[p]),
            .cpu_rsp (cpu_rsp[p]),
            .mem_req (cache_mem_req[p]),
            .mem_rsp (cache_mem_rsp[p])
        );
    end

    memory_arbiter i_memory_arbiter (
        .clk,
        .reset,
        .cache_req (cache_mem_req),
        .cache_rsp (cache_mem_rsp),
        .mem_rsp,
        .mem_req
    );

    main_memory i_main_memory (
        .clk,
        .reset,
        .mem_req,
        .mem_rsp
    );

endmodule : cache_system

// ==== logic/main_memory.sv ====
`timescale 1ns/100ps

module main_memory import cache_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  mem_req_t mem_req,
    output mem_rsp_t mem_rsp
);

    logic [line_width-1:0]          mem_q [2**line_addr_width];
    logic [line_width-1:0]          rd_dat_q;
    logic [$clog2(mem_latency)-1:0] cnt_q;            // Cycles left to ack
    logic                           active_q;         // Request accepted
    logic                           ack_q;
    logic                           fire;

    assign fire    = active_q && (cnt_q == 1);        // Access in last wait cycle
    assign mem_rsp = '{ack: ack_q, dat: rd_dat_q};

    always_ff @(posedge clk) begin
        if (reset) begin
            active_q <= 1'b0;
            ack_q    <= 1'b0;
            cnt_q    <= '0;
        end else begin
            ack_q <= fire;                            // One cycle pulse
            if (fire) begin
                active_q <= 1'b0;
            end else if (active_q) begin
                cnt_q <= cnt_q - 1'b1;
            end else if (mem_req.stb && !ack_q) begin // Stb still high in ack cycle
                active_q <= 1'b1;
                cnt_q    <= $bits(cnt_q)'(mem_latency - 1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            if (mem_req.we) mem_q[mem_req.adr] <= mem_req.dat;
            else rd_dat_q <= mem_q[mem_req.adr];
        end
    end

    // Arbiter and cache must hold the request until ack
    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        active_q |-> mem_req.stb && $stable({mem_req.we, mem_req.adr, mem_req.dat}));

endmodule : main_memory

// ==== logic/memory_arbiter.sv ====
`timescale 1ns/100ps

module memory_arbiter import cache_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  mem_req_t cache_req [num_ports],           // One per cache
    output mem_rsp_t cache_rsp [num_ports],
    input  mem_rsp_t mem_rsp,                         // From main memory
    output mem_req_t mem_req
);

    logic                  busy_q;                    // Bus granted, waiting for ack
    logic [port_width-1:0] owner_q;
    logic [port_width-1:0] last_q;                    // Last port served
    logic [port_width-1:0] pick;                      // Round-robin choice
    logic [port_width-1:0] grant;
    logic                  found;

    // Search starts at the port after the last one served
    always_comb begin
        int unsigned idx;
        pick  = last_q;
        found = 1'b0;
        for (int k = 1; k <= num_ports; k++) begin
            idx = (int'(last_q) + k) % num_ports;
            if (!found && cache_req[idx].stb) begin
                pick  = port_width'(idx);
                found = 1'b1;
            end
        end
    end

    assign grant   = busy_q ? owner_q : pick;         // Combinational grant when free
    assign mem_req = cache_req[grant];

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q  <= 1'b0;
            owner_q <= '0;
            last_q  <= port_width'(num_ports - 1);    // Port 0 first
        end else if (!busy_q) begin
            if (found) begin
                busy_q  <= 1'b1;
                owner_q <= pick;
                last_q  <= pick;
            end
        end else if (mem_rsp.ack) begin
            busy_q <= 1'b0;                           // Free from next cycle
        end
    end

    for (genvar i = 0; i < num_ports; i++) begin : g_rsp
        assign cache_rsp[i].ack = mem_rsp.ack && busy_q && (owner_q == i);
        assign cache_rsp[i].dat = mem_rsp.dat;        // Data fans out to all

        // Ack only to a port that still holds its request
        a_ack_owner: assert property (@(posedge clk) disable iff (reset)
            cache_rsp[i].ack |-> cache_req[i].stb);
    end

endmodule : memory_arbiter

// ==== logic/cache.sv ====
`timescale 1ns/100ps

module cache import cache_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  cpu_req_t cpu_req,                         // Processor port
    output cpu_rsp_t cpu_rsp,
    output mem_req_t mem_req,                         // Shared memory bus
    input  mem_rsp_t mem_rsp
);

    // Control to datapath
    logic cache_way_sel;
    logic data_source_sel;
    logic tag_bypass_sel;
    logic load;
    logic load_type;
    logic load_lru;

    // Datapath to control
    logic hit_0;
    logic hit_1;
    logic dirty;
    logic lru;

    // Fields packed back into the structs
    logic                       cpu_ack;
    logic [word_width-1:0]      cpu_dat_out;
    logic                       mem_stb;
    logic                       mem_we;
    logic [line_addr_width-1:0] mem_adr;
    logic [line_width-1:0]      mem_dat_out;

    assign cpu_rsp = '{ack: cpu_ack, dat: cpu_dat_out};
    assign mem_req = '{stb: mem_stb, we: mem_we, adr: mem_adr, dat: mem_dat_out};

    cache_datapath i_cache_datapath (
        .clk,
        .reset,
        .cache_way_sel,
        .data_source_sel,
        .tag_bypass_sel,
        .load,
        .load_type,
        .load_lru,
        .cpu_adr    (cpu_req.adr),
        .cpu_sel    (cpu_req.sel),
        .cpu_dat    (cpu_req.dat),
        .mem_dat_in (mem_rsp.dat),                    // Fill data
        .hit_0,
        .hit_1,
        .dirty,
        .lru,
        .cpu_dat_out,
        .mem_adr,
        .mem_dat_out
    );

    cache_control i_cache_control (
        .clk,
        .reset,
        .hit_0,
        .hit_1,
        .dirty,
        .lru,
        .cpu_stb (cpu_req.stb),
        .cpu_we  (cpu_req.we),
        .mem_ack (mem_rsp.ack),                       // Only this cache's acks arrive
        .cache_way_sel,
        .data_source_sel,
        .tag_bypass_sel,
        .load,
        .load_type,
        .load_lru,
        .cpu_ack,
        .mem_stb,
        .mem_we
    );

endmodule : cache

// ==== logic/cache_control.sv ====
`timescale 1ns/100ps

module cache_control (
    input  logic clk,
    input  logic reset,
    // From datapath
    input  logic hit_0,
    input  logic hit_1,
    input  logic dirty,
    input  logic lru,
    // From processor
    input  logic cpu_stb,
    input  logic cpu_we,
    // From memory bus
    input  logic mem_ack,
    // To datapath
    output logic cache_way_sel,
    output logic data_source_sel,
    output logic tag_bypass_sel,
    output logic load,
    output logic load_type,
    output logic load_lru,
    // To processor
    output logic cpu_ack,
    // To memory bus
    output logic mem_stb,
    output logic mem_we
);

    typedef enum logic [2:0] {
        st_idle,
        st_compare,
        st_write_back,
        st_allocate,
        st_respond
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   hit;
    logic   ack_q;                                    // Memory ack seen last cycle

    assign hit = hit_0 | hit_1;
    assign cache_way_sel = hit ? hit_1 : lru;         // Victim is the LRU way

    always_comb begin
        state_d         = state_q;
        data_source_sel = 1'b0;
        tag_bypass_sel  = 1'b0;
        load            = 1'b0;
        load_type       = 1'b0;
        load_lru        = 1'b0;
        cpu_ack         = 1'b0;
        mem_stb         = 1'b0;
        mem_we          = 1'b0;
        case (state_q)
            st_idle: begin
                if (cpu_stb) state_d = st_compare;
            end
            st_compare: begin
                if (hit) begin
                    load     = cpu_we;                // Merge write into the hit way
                    load_lru = 1'b1;
                    state_d  = st_respond;
                end else if (dirty) begin
                    state_d = st_write_back;
                end else begin
                    state_d = st_allocate;
                end
            end
            st_write_back: begin
                mem_stb = 1'b1;
                mem_we  = 1'b1;
                if (mem_ack) state_d = st_allocate;
            end
            st_allocate: begin
                mem_stb         = ~ack_q;             // Idle one cycle after write-back ack
                tag_bypass_sel  = 1'b1;
                data_source_sel = 1'b1;
                load_type       = 1'b1;
                load            = mem_ack;            // Fill on ack
                if (mem_ack) state_d = st_compare;    // Resolves as a hit
            end
            st_respond: begin
                cpu_ack = 1'b1;
                state_d = st_idle;
            end
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= st_idle;
            ack_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            ack_q   <= mem_ack;
        end
    end

    // Processor must still hold its request when answered
    a_ack_with_stb: assert property (@(posedge clk) disable iff (reset) cpu_ack |-> cpu_stb);

endmodule : cache_control

// ==== logic/cache_datapath.sv ====
`timescale 1ns/100ps

module cache_datapath import cache_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    // From control
    input  logic                       cache_way_sel,   // Way being accessed
    input  logic                       data_source_sel, // 1 = memory line, 0 = merged write
    input  logic                       tag_bypass_sel,  // 1 = request tag, 0 = victim tag
    input  logic                       load,
    input  logic                       load_type,       // 1 = fill, 0 = processor write
    input  logic                       load_lru,
    // From processor
    input  logic [addr_width-1:0]      cpu_adr,
    input  logic [word_bytes-1:0]      cpu_sel,
    input  logic [word_width-1:0]      cpu_dat,
    // From memory
    input  logic [line_width-1:0]      mem_dat_in,
    // To control
    output logic                       hit_0,
    output logic                       hit_1,
    output logic                       dirty,
    output logic                       lru,
    // To processor and memory
    output logic [word_width-1:0]      cpu_dat_out,
    output logic [line_addr_width-1:0] mem_adr,
    output logic [line_width-1:0]      mem_dat_out
);

    logic [tag_width-1:0]      req_tag;
    logic [index_width-1:0]    set_idx;
    logic [word_sel_width-1:0] word_idx;

    logic [tag_width-1:0]  tag_q  [2][num_sets];      // Per way, per set
    logic [line_width-1:0] line_q [2][num_sets];
    logic [num_sets-1:0]   valid_q [2];
    logic [num_sets-1:0]   dirty_q [2];
    logic [num_sets-1:0]   lru_q;                     // Least recently used way per set

    logic [line_width-1:0] way_line;                  // Line of the selected way
    logic [line_width-1:0] merge_line;
    logic [line_width-1:0] new_line;

    // Split address into tag, set and word
    assign {req_tag, set_idx} = cpu_adr[addr_width-1:offset_width];
    assign word_idx = cpu_adr[offset_width-1 -: word_sel_width];

    assign hit_0 = valid_q[0][set_idx] && (tag_q[0][set_idx] == req_tag);
    assign hit_1 = valid_q[1][set_idx] && (tag_q[1][set_idx] == req_tag);
    assign lru   = lru_q[set_idx];
    assign dirty = valid_q[cache_way_sel][set_idx] && dirty_q[cache_way_sel][set_idx];

    assign way_line    = line_q[cache_way_sel][set_idx];
    assign cpu_dat_out = way_line[word_idx*word_width +: word_width]; // Word for reads
    assign mem_dat_out = way_line;                                    // Victim on write-back

    // Fill uses the request tag, write-back the stored one
    assign mem_adr = {tag_bypass_sel ? req_tag : tag_q[cache_way_sel][set_idx], set_idx};

    // Byte merge of the processor word into the cached line
    always_comb begin
        merge_line = way_line;
        for (int b = 0; b < word_bytes; b++) begin
            if (cpu_sel[b]) begin
                merge_line[word_idx*word_width + b*8 +: 8] = cpu_dat[b*8 +: 8];
            end
        end
    end

    assign new_line = data_source_sel ? mem_dat_in : merge_line;

    // Tag and line arrays
    always_ff @(posedge clk) begin
        if (load) begin
            line_q[cache_way_sel][set_idx] <= new_line;
            if (load_type) begin
                tag_q[cache_way_sel][set_idx] <= req_tag; // New owner of the way
            end
        end
    end

    // Valid, dirty and LRU bits
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '{default: '0};
            dirty_q <= '{default: '0};
            lru_q   <= '0;
        end else begin
            if (load) begin
                if (load_type) begin
                    valid_q[cache_way_sel][set_idx] <= 1'b1;
                    dirty_q[cache_way_sel][set_idx] <= 1'b0; // Fresh copy of memory
                end else begin
                    dirty_q[cache_way_sel][set_idx] <= 1'b1;
                end
            end
            if (load_lru) begin
                lru_q[set_idx] <= ~cache_way_sel;            // Other way becomes LRU
            end
        end
    end

endmodule : cache_datapath

// ==== logic/cache_pkg.sv ====
package cache_pkg;

    // Processor side
    localparam int addr_width = 12;                   // Byte address
    localparam int word_bytes = 4;
    localparam int word_width = 8 * word_bytes;       // 32 bit word

    // Line geometry
    localparam int line_words = 4;
    localparam int line_width = line_words * word_width;        // 128 bits
    localparam int word_sel_width = $clog2(line_words);         // Word within line
    localparam int num_sets = 8;
    localparam int index_width = $clog2(num_sets);              // 3 bits
    localparam int offset_width = $clog2(line_words * word_bytes); // 4 bits
    localparam int tag_width = addr_width - index_width - offset_width; // 5 bits
    localparam int line_addr_width = tag_width + index_width;   // 256 lines in memory

    // Shared bus
    localparam int num_ports = 2;                     // Caches on the memory bus
    localparam int port_width = 1;                    // Owner and pointer width
    localparam int mem_latency = 4;                   // Stb sample to ack

    typedef struct packed {
        logic                  stb;
        logic                  we;                    // 1 = write
        logic [addr_width-1:0] adr;
        logic [word_bytes-1:0] sel;                   // Byte lanes for writes
        logic [word_width-1:0] dat;
    } cpu_req_t;

    typedef struct packed {
        logic                  ack;                   // One cycle pulse
        logic [word_width-1:0] dat;                   // Read data in ack cycle
    } cpu_rsp_t;

    typedef struct packed {
        logic                       stb;
        logic                       we;
        logic [line_addr_width-1:0] adr;              // Line address
        logic [line_width-1:0]      dat;
    } mem_req_t;

    typedef struct packed {
        logic                  ack;
        logic [line_width-1:0] dat;
    } mem_rsp_t;

endpackage : cache_pkg
